//--- test/fcvtStimulus.txt
# columns: tag (0 single, 1 double), operand (16 hex), expected quad (32 hex)
# single operands use the low 32 bits of the operand
0 000000003F800000 3FFF0000000000000000000000000000
1 3FF0000000000000 3FFF0000000000000000000000000000
0 00000000C0200000 C0004000000000000000000000000000
1 BFB999999999999A BFFB999999999999A000000000000000
0 000000007F7FFFFF 407EFFFFFE0000000000000000000000
1 C009000000000000 C0009000000000000000000000000000
0 DEADBEEF3F800000 3FFF0000000000000000000000000000
0 0000000000000001 3F6A0000000000000000000000000000
1 0000000000000001 3BCD0000000000000000000000000000
0 0000000080400000 BF800000000000000000000000000000
1 8008000000000000 BC000000000000000000000000000000
0 0000000000300000 3F7F8000000000000000000000000000
1 0000000000000003 3BCE8000000000000000000000000000
0 0000000000000000 00000000000000000000000000000000
1 8000000000000000 80000000000000000000000000000000
0 0000000080000000 80000000000000000000000000000000
0 000000007F800000 7FFF0000000000000000000000000000
1 FFF0000000000000 FFFF0000000000000000000000000000
0 000000007FC00000 7FFF8000000000000000000000000000
0 000000007F800001 7FFF8000020000000000000000000000
0 00000000FFA00001 FFFFC000020000000000000000000000
1 7FF0000000000001 7FFF8000000000001000000000000000
1 FFF8000000000123 FFFF8000000000123000000000000000

//--- tb.f
hdl/fcvtPkg.sv
hdl/fpDecomp.sv
hdl/fcvtsq.sv
hdl/fcvtdq.sv
hdl/fcvtMerge.sv
hdl/fcvtUnit.sv
test/fcvtUnitAsserts.sv
test/fcvtUnitTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the widening unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fcvtUnitTb -f tb.f > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/VfcvtUnitTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" sim.log; then
    exit 0
fi
exit 1

//--- test/fcvtUnitTb.sv
`timescale 1ns/100ps
/*
 * Float widening unit testbench
 * streams operands from the stimulus file under upstream credit control,
 * models a consumer that returns credits late, and checks results in order
 */
module fcvtUnitTb import fcvtPkg::*; ();

    // cycles any single wait may take before the run is abandoned
    localparam int WAIT_LIMIT = 400;
    // cycles without an issue before the unit counts as idle
    localparam int QUIET_CYCLES = 8;

    logic    clk;
    logic    rstN;
    logic    inValid;
    fmtT     inFmt;
    operandT inOperand;
    logic    inCredit;
    logic    outValid;
    quadT    outResult;
    logic    outCredit;

    // vectors from the stimulus file
    fmtT     vecFmt [$];
    operandT vecOp [$];
    quadT    vecExp [$];
    // scoreboard, expected results in issue order
    quadT    expQ [$];
    // cycle at which each held consumer slot is handed back
    int      dueQ [$];

    int upCredits;
    int outstanding;
    int cycle;
    int errors;
    int checks;
    int holdSink;
    int errBefore;

    fcvtUnit DUT (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inFmt     (inFmt),
        .inOperand (inOperand),
        .inCredit  (inCredit),
        .outValid  (outValid),
        .outResult (outResult),
        .outCredit (outCredit)
    );

    always #2 clk = ~clk;

    // ======================================================================
    // checks and reporting
    // ======================================================================
    task automatic compareQuad(input quadT got, input quadT expd);
        checks++;
        if (got !== expd)
        begin
            errors++;
            $display("ERROR @%0t: result %h, expected %h", $time, got, expd);
        end
    endtask

    task automatic compareCredits(input creditT got, input creditT expd, input string what);
        checks++;
        if (got !== expd)
        begin
            errors++;
            $display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, expd);
        end
    endtask

    task automatic reportTest(input string name);
        $display("TEST %s: %s", name, (errors == errBefore) ? "ok" : "FAILED");
        errBefore = errors;
    endtask

    task automatic abortRun(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Verification failed");
        $finish;
    endtask

    // ======================================================================
    // stimulus file
    // ======================================================================
    task automatic loadVectors();
        int      fd;
        int      n;
        int      tag;
        string   line;
        operandT op;
        quadT    expd;
        fd = $fopen("test/fcvtStimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file test/fcvtStimulus.txt");
            $display("Verification failed");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                // comment lines open with a hash
                if (line.len() == 0 || line.substr(0, 0) == "#")
                    continue;
                n = $sscanf(line, "%d %h %h", tag, op, expd);
                if (n == 3)
                begin
                    vecFmt.push_back((tag == 1) ? fmtDouble : fmtSingle);
                    vecOp.push_back(op);
                    vecExp.push_back(expd);
                end
            end
            $fclose(fd);
        end
    endtask

    // ======================================================================
    // upstream driver, owns the upstream credit count
    // ======================================================================
    // credit pulse seen now lands at the coming edge, so count it after use
    task automatic takeCredit();
        if (inCredit)
            upCredits++;
    endtask

    task automatic idleCycle();
        @(negedge clk);
        inValid = 1'b0;
        takeCredit();
    endtask

    task automatic sendOperand(input int idx);
        int waited;
        waited = 0;
        @(negedge clk);
        while (upCredits == 0)
        begin
            inValid = 1'b0;
            takeCredit();
            waited++;
            if (waited > WAIT_LIMIT)
                abortRun("an upstream credit");
            @(negedge clk);
        end
        inValid   = 1'b1;
        inFmt     = vecFmt[idx];
        inOperand = vecOp[idx];
        upCredits--;
        expQ.push_back(vecExp[idx]);
        takeCredit();
    endtask

    // idle once no result has issued for a while and the consumer holds no slot
    task automatic waitDrain();
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        while (quiet < QUIET_CYCLES || dueQ.size() != 0)
        begin
            idleCycle();
            quiet = outValid ? 0 : quiet + 1;
            waited++;
            if (waited > WAIT_LIMIT)
                abortRun("the unit to go idle");
        end
    endtask

    // ======================================================================
    // consumer model and output monitor
    // ======================================================================
    always @(negedge clk)
    begin
        if (rstN)
        begin
            cycle++;
            if (outValid)
            begin
                if (outstanding >= SINK_CREDITS)
                begin
                    errors++;
                    $display("ERROR @%0t: outValid with no downstream credit left", $time);
                end
                outstanding++;
                dueQ.push_back(cycle + int'($urandom_range(3, 0)));
                if (expQ.size() == 0)
                begin
                    errors++;
                    $display("ERROR @%0t: result %h with nothing expected", $time, outResult);
                end
                else
                    compareQuad(outResult, expQ.pop_front());
            end
            // one slot back per cycle, none while the consumer stalls
            outCredit = 1'b0;
            if (holdSink == 0 && dueQ.size() != 0 && dueQ[0] <= cycle)
            begin
                void'(dueQ.pop_front());
                outCredit = 1'b1;
                outstanding--;
            end
        end
    end

    // ======================================================================
    // test sequence
    // ======================================================================
    initial
    begin
        int waited;
        void'($urandom(67));
        clk         = 1'b0;
        rstN        = 1'b0;
        inValid     = 1'b0;
        inFmt       = fmtSingle;
        inOperand   = '0;
        outCredit   = 1'b0;
        holdSink    = 0;
        upCredits   = QUEUE_DEPTH;
        outstanding = 0;
        cycle       = 0;
        errors      = 0;
        checks      = 0;
        errBefore   = 0;
        loadVectors();
        repeat (8) @(negedge clk);
        rstN = 1'b1;

        // normals, subnormals and specials, formats interleaved back to back
        for (int i = 0; i < vecOp.size(); i++)
            sendOperand(i);
        waitDrain();
        compareCredits(creditT'(expQ.size()), creditT'(0), "results missing from the stream");
        reportTest("conversion stream");

        // consumer stalls, unit fills the sink and then its own queue
        holdSink = 1;
        for (int i = 0; i < QUEUE_DEPTH + SINK_CREDITS; i++)
            sendOperand(i % vecOp.size());
        waited = 0;
        while (outstanding != SINK_CREDITS)
        begin
            idleCycle();
            waited++;
            if (waited > WAIT_LIMIT)
                abortRun("the consumer buffer to fill");
        end
        for (int i = 0; i < 4; i++)
            idleCycle();
        compareCredits(creditT'(upCredits), creditT'(0), "upstream credits while stalled");
        compareCredits(creditT'(outstanding), creditT'(SINK_CREDITS), "held sink slots");
        holdSink = 0;
        waitDrain();
        reportTest("back-pressure");

        compareCredits(creditT'(upCredits), creditT'(QUEUE_DEPTH), "upstream credits at end");
        compareCredits(creditT'(expQ.size()), creditT'(0), "unconsumed results");
        reportTest("end of run");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- test/fcvtUnitAsserts.sv
`timescale 1ns/100ps
/*
 * Credit protocol assertions for the widening merge stage
 * bound into every fcvtMerge instance
 */
module fcvtUnitAsserts import fcvtPkg::*; (
    input logic clk,
    input logic rstN,
    input logic inValid,
    input logic queueFull,
    input logic outValid,
    input logic outCredit,
    input logic inCredit,
    input qPtrT wrPtr,
    input qPtrT rdPtr
);

    // consumer slots as seen at the ports, apart from the stage's own counter
    creditT sinkSeen;

    always_ff @(posedge clk)
    begin
        if (!rstN)
            sinkSeen <= creditT'(SINK_CREDITS);
        else if (outValid && !outCredit)
            sinkSeen <= sinkSeen - 1'b1;
        else if (!outValid && outCredit)
            sinkSeen <= sinkSeen + 1'b1;
    end

    // upstream credits keep a valid off a full queue
    aNoPushWhenFull: assert property (
        @(posedge clk) disable iff (!rstN) !(inValid && queueFull))
        else $error("input arrived while the result queue was full");

    // no issue without a consumer slot
    aNoIssueWithoutCredit: assert property (
        @(posedge clk) disable iff (!rstN) outValid |-> (sinkSeen != '0))
        else $error("outValid with a zero downstream count");

    // a returned credit frees an entry the pointers still hold
    aCreditFreesEntry: assert property (
        @(posedge clk) disable iff (!rstN) inCredit |-> ((wrPtr != rdPtr) || queueFull))
        else $error("inCredit with no entry held in the result queue");

endmodule

bind fcvtMerge fcvtUnitAsserts uAsserts (
    .clk       (clk),
    .rstN      (rstN),
    .inValid   (inValid),
    .queueFull (queueFull),
    .outValid  (outValid),
    .outCredit (outCredit),
    .inCredit  (inCredit),
    .wrPtr     (wrPtr),
    .rdPtr     (rdPtr)
);

//--- hdl/fcvtUnit.sv
`timescale 1ns/100ps
/*
 * Float widening unit, top level
 * single and double converters run in parallel on every operand
 * and the merge stage keeps the one named by the tag
 */
module fcvtUnit import fcvtPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    input  fmtT     inFmt,
    input  operandT inOperand,
    output logic    inCredit,
    output logic    outValid,
    output quadT    outResult,
    input  logic    outCredit
);

    // converter outputs, both valid every cycle
    quadT sglQuad;
    quadT dblQuad;

    // low word as binary32
    fcvtsq uSgl (
        .a (inOperand),
        .o (sglQuad)
    );

    // full word as binary64
    fcvtdq uDbl (
        .a (inOperand),
        .o (dblQuad)
    );

    // tag select, result queue, credit flow
    fcvtMerge uMerge (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inFmt     (inFmt),
        .sglQuad   (sglQuad),
        .dblQuad   (dblQuad),
        .inCredit  (inCredit),
        .outValid  (outValid),
        .outResult (outResult),
        .outCredit (outCredit)
    );

endmodule

//--- hdl/fcvtMerge.sv
`timescale 1ns/100ps
/*
 * Widening merge stage
 * picks the converter result named by the format tag, holds it in a
 * small result queue and runs credit flow on both sides
 */
module fcvtMerge import fcvtPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    input  fmtT  inFmt,
    input  quadT sglQuad,
    input  quadT dblQuad,
    output logic inCredit,
    output logic outValid,
    output quadT outResult,
    input  logic outCredit
);

    // result storage, payload only
    quadT   queueMem [QUEUE_DEPTH];
    qPtrT   wrPtr;
    qPtrT   rdPtr;
    // entries currently held
    creditT occCount;
    // free slots in the consumer buffer
    creditT sinkCredit;
    quadT   selQuad;
    logic   queueFull;
    logic   queueEmpty;
    logic   push;
    logic   pop;

    // ======================================================================
    // format select and queue status
    // ======================================================================
    assign selQuad    = (inFmt == fmtDouble) ? dblQuad : sglQuad;
    assign queueFull  = (occCount == creditT'(QUEUE_DEPTH));
    assign queueEmpty = (occCount == '0);

    // upstream credits keep a valid off a full queue
    // the full check only guards the storage
    assign push = inValid && !queueFull;
    // issue needs a queued result and a free slot downstream
    assign pop  = !queueEmpty && (sinkCredit != '0);

    assign outValid  = pop;
    assign outResult = queueMem[rdPtr];
    // freed entry goes straight back upstream as a credit
    assign inCredit  = pop;

    // ======================================================================
    // queue storage
    // ======================================================================
    // written at the accepting edge, readable the next cycle
    always_ff @(posedge clk)
    begin
        if (push)
            queueMem[wrPtr] <= selQuad;
    end

    // pointers and occupancy
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            occCount <= '0;
        end
        else
        begin
            if (push)
                wrPtr <= wrPtr + 1'b1;
            if (pop)
                rdPtr <= rdPtr + 1'b1;
            case ({push, pop})
                2'b10:   occCount <= occCount + 1'b1;
                2'b01:   occCount <= occCount - 1'b1;
                default: occCount <= occCount;
            endcase
        end
    end

    // ======================================================================
    // downstream credit counter
    // ======================================================================
    // issue spends a slot, outCredit returns one, both may land together
    always_ff @(posedge clk)
    begin
        if (!rstN)
            sinkCredit <= creditT'(SINK_CREDITS);
        else
        begin
            case ({pop, outCredit})
                2'b10:   sinkCredit <= sinkCredit - 1'b1;
                2'b01:   sinkCredit <= sinkCredit + 1'b1;
                default: sinkCredit <= sinkCredit;
            endcase
        end
    end

endmodule

//--- hdl/fcvtdq.sv
`timescale 1ns/100ps
/*
 * Double to quad widening converter
 * combinational, exact, same class rules as the single path
 */
module fcvtdq import fcvtPkg::*; (
    input  operandT a,
    output quadT    o
);

    logic                                 sgn;
    logic [DBL_EXP_BITS-1:0]              expIn;
    logic [DBL_FRAC_BITS-1:0]             manIn;
    logic                                 isZero;
    logic                                 isSub;
    logic                                 isInf;
    logic                                 isNan;
    logic [$clog2(DBL_FRAC_BITS)-1:0]     lz;
    logic [DBL_FRAC_BITS-1:0]             manNorm;

    // full 64-bit operand
    fpDecomp #(.WID(64)) uDecomp (
        .i      (a),
        .sgn    (sgn),
        .exp    (expIn),
        .man    (manIn),
        .isZero (isZero),
        .isSub  (isSub),
        .isInf  (isInf),
        .isNan  (isNan)
    );

    // leading zero count over the 52-bit fraction
    // last hit in the upward scan is the most significant one
    always_comb
    begin
        lz = '0;
        for (int b = 0; b < DBL_FRAC_BITS; b++)
        begin
            if (manIn[b])
                lz = ($clog2(DBL_FRAC_BITS))'(DBL_FRAC_BITS - 1 - b);
        end
    end

    // drop the leading one, remaining bits become the quad fraction
    assign manNorm = manIn << (lz + 1'b1);

    always_comb
    begin
        o = '0;
        o[QUAD_EXP_BITS + QUAD_FRAC_BITS] = sgn;
        if (isNan)
        begin
            // payload kept, top fraction bit marks it quiet
            o[QUAD_FRAC_BITS +: QUAD_EXP_BITS]        = '1;
            o[QUAD_FRAC_BITS-1 -: DBL_FRAC_BITS]      = manIn;
            o[QUAD_FRAC_BITS-1]                       = 1'b1;
        end
        else if (isInf)
            o[QUAD_FRAC_BITS +: QUAD_EXP_BITS] = '1;
        else if (isSub)
        begin
            // 1.f * 2^(-1023-lz) lands well inside the quad range
            o[QUAD_FRAC_BITS +: QUAD_EXP_BITS] =
                QUAD_EXP_BITS'(DBL_TO_QUAD_BIAS) - QUAD_EXP_BITS'(lz);
            o[QUAD_FRAC_BITS-1 -: DBL_FRAC_BITS] = manNorm;
        end
        else if (!isZero)
        begin
            // rebias, fraction goes to the top of the field
            o[QUAD_FRAC_BITS +: QUAD_EXP_BITS] =
                QUAD_EXP_BITS'(expIn) + QUAD_EXP_BITS'(DBL_TO_QUAD_BIAS);
            o[QUAD_FRAC_BITS-1 -: DBL_FRAC_BITS] = manIn;
        end
    end

endmodule

//--- hdl/fcvtsq.sv
`timescale 1ns/100ps
/*
 * Single to quad widening converter
 * combinational, exact, normalizes subnormals and quiets NaNs
 */
module fcvtsq import fcvtPkg::*; (
    input  operandT a,
    output quadT    o
);

    logic                                 sgn;
    logic [SGL_EXP_BITS-1:0]              expIn;
    logic [SGL_FRAC_BITS-1:0]             manIn;
    logic                                 isZero;
    logic                                 isSub;
    logic                                 isInf;
    logic                                 isNan;
    logic [$clog2(SGL_FRAC_BITS)-1:0]     lz;
    logic [SGL_FRAC_BITS-1:0]             manNorm;

    // binary32 sits in the low word
    fpDecomp #(.WID(32)) uDecomp (
        .i      (a[31:0]),
        .sgn    (sgn),
        .exp    (expIn),
        .man    (manIn),
        .isZero (isZero),
        .isSub  (isSub),
        .isInf  (isInf),
        .isNan  (isNan)
    );

    // leading zero count over the fraction
    // scan upward so the highest set bit is the last one assigned
    always_comb
    begin
        lz = '0;
        for (int b = 0; b < SGL_FRAC_BITS; b++)
        begin
            if (manIn[b])
                lz = ($clog2(SGL_FRAC_BITS))'(SGL_FRAC_BITS - 1 - b);
        end
    end

    // move the leading one out of the field, it becomes the hidden bit
    assign manNorm = manIn << (lz + 1'b1);

    always_comb
    begin
        o = '0;
        o[QUAD_EXP_BITS + QUAD_FRAC_BITS] = sgn;
        if (isNan)
        begin
            // keep payload, force quiet bit
            o[QUAD_FRAC_BITS +: QUAD_EXP_BITS]        = '1;
            o[QUAD_FRAC_BITS-1 -: SGL_FRAC_BITS]      = manIn;
            o[QUAD_FRAC_BITS-1]                       = 1'b1;
        end
        else if (isInf)
            o[QUAD_FRAC_BITS +: QUAD_EXP_BITS] = '1;
        else if (isSub)
        begin
            // value 1.f * 2^(-127-lz) is normal in quad
            o[QUAD_FRAC_BITS +: QUAD_EXP_BITS] =
                QUAD_EXP_BITS'(SGL_TO_QUAD_BIAS) - QUAD_EXP_BITS'(lz);
            o[QUAD_FRAC_BITS-1 -: SGL_FRAC_BITS] = manNorm;
        end
        else if (!isZero)
        begin
            // normal operand, rebias and left-align fraction
            o[QUAD_FRAC_BITS +: QUAD_EXP_BITS] =
                QUAD_EXP_BITS'(expIn) + QUAD_EXP_BITS'(SGL_TO_QUAD_BIAS);
            o[QUAD_FRAC_BITS-1 -: SGL_FRAC_BITS] = manIn;
        end
    end

endmodule

//--- hdl/fpDecomp.sv
`timescale 1ns/100ps
/*
 * IEEE 754 operand decomposer
 * splits a binary32 or binary64 word into sign, biased exponent and
 * fraction, and flags zero, subnormal, infinity and NaN
 */
module fpDecomp #(
    parameter int WID = 32,
    // field widths follow from the container width
    localparam int EXP_BITS  = (WID == 64) ? 11 : 8,
    localparam int FRAC_BITS = (WID == 64) ? 52 : 23
) (
    input  logic [WID-1:0]       i,
    output logic                 sgn,
    output logic [EXP_BITS-1:0]  exp,
    output logic [FRAC_BITS-1:0] man,
    output logic                 isZero,
    output logic                 isSub,
    output logic                 isInf,
    output logic                 isNan
);

    logic expAllZero;
    logic expAllOnes;
    logic manZero;

    // field split
    // sign on top, exponent next, fraction in the low bits
    assign sgn = i[WID-1];
    assign exp = i[WID-2 -: EXP_BITS];
    assign man = i[FRAC_BITS-1:0];

    // exponent extremes select the special classes
    assign expAllZero = ~|exp;
    assign expAllOnes = &exp;
    assign manZero    = ~|man;

    // ======================================================================
    // class decode
    // ======================================================================
    // zero exponent, zero fraction
    assign isZero = expAllZero & manZero;
    // zero exponent, something in the fraction
    assign isSub  = expAllZero & ~manZero;
    // saturated exponent, empty fraction
    assign isInf  = expAllOnes & manZero;
    // saturated exponent with payload, quiet or signaling alike
    assign isNan  = expAllOnes & ~manZero;

endmodule

//--- hdl/fcvtPkg.sv
/*
 * Float widening package
 * field widths, exponent rebias constants, credit depths and the
 * vector types shared by the widening converters and the merge stage
 */
package fcvtPkg;

    // ======================================================================
    // IEEE 754 field widths
    // ======================================================================
    localparam int SGL_EXP_BITS   = 8;
    localparam int SGL_FRAC_BITS  = 23;
    localparam int DBL_EXP_BITS   = 11;
    localparam int DBL_FRAC_BITS  = 52;
    localparam int QUAD_EXP_BITS  = 15;
    localparam int QUAD_FRAC_BITS = 112;

    // quad bias 16383 minus single bias 127
    localparam int SGL_TO_QUAD_BIAS = 16256;
    // quad bias 16383 minus double bias 1023
    localparam int DBL_TO_QUAD_BIAS = 15360;

    // ======================================================================
    // flow control
    // ======================================================================
    // result queue entries, also upstream credits after reset
    localparam int QUEUE_DEPTH  = 4;
    // consumer buffer slots, also downstream credits after reset
    localparam int SINK_CREDITS = 4;

    // ======================================================================
    // types
    // ======================================================================
    typedef logic [127:0] quadT;
    // single operand lives in the low 32 bits
    typedef logic [63:0]  operandT;
    // holds 0 to 4 inclusive
    typedef logic [2:0]   creditT;
    // queue index, depth is a power of two so pointers wrap on their own
    typedef logic [$clog2(QUEUE_DEPTH)-1:0] qPtrT;

    // source format tag carried with every operand
    typedef enum logic
    {
        fmtSingle = 1'b0,
        fmtDouble = 1'b1
    } fmtT;

endpackage
